// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fp_wb_tb
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = FAIL: see errors above

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/fp_latency_timer.sv ====
// Execution latency timer
// Down-counter loaded on start; expired marks the last busy cycle

`timescale 1ns/1ps

module fp_latency_timer #(
    parameter int LATENCY = 4
) (
    input logic clk,
    input logic rst,
    input logic start,
    output logic expired
);

    localparam int CNT_W = $clog2(LATENCY);

    logic [CNT_W-1:0] count;

    // Load LATENCY-1, count down, park at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_W'(LATENCY - 1);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign expired = (count == CNT_W'(1));

endmodule

// ==== design/fp_minmax_unit.sv ====
// Min/max execution unit
// FMIN and FMAX with IEEE 754-2019 NaN and signed-zero handling,
// fixed LATENCY cycles from acceptance to done

`timescale 1ns/1ps

module fp_minmax_unit import fp_wb_pkg::*; #(
    parameter int LATENCY = 4
) (
    input logic clk,
    input logic rst,
    input logic start,
    input fp_op_e op,
    input id_t id,
    input logic [FLEN-1:0] a,
    input logic [FLEN-1:0] b,
    output logic ready,
    fp_unit_wb_if.unit wb
);

    localparam int FRAC_W = 23;
    localparam int EXP_W = FLEN - 1 - FRAC_W;

    logic timer_start;
    logic timer_expired;
    logic capture;
    logic ctrl_done;

    fp_op_e op_q;
    id_t id_q;
    logic [FLEN-1:0] a_q;
    logic [FLEN-1:0] b_q;

    logic a_nan;
    logic b_nan;
    logic a_snan;
    logic b_snan;
    logic a_lt_b;
    logic [FLEN-1:0] result;

    ////////////////////////////////////////
    // Control and timing
    fp_unit_ctrl ctrl (
        .clk (clk),
        .rst (rst),
        .start (start),
        .timer_expired (timer_expired),
        .ack (wb.ack),
        .ready (ready),
        .timer_start (timer_start),
        .capture (capture),
        .done (ctrl_done)
    );

    fp_latency_timer #(.LATENCY(LATENCY)) timer (
        .clk (clk),
        .rst (rst),
        .start (timer_start),
        .expired (timer_expired)
    );

    // Operand capture
    always_ff @(posedge clk) begin
        if (capture) begin
            op_q <= op;
            id_q <= id;
            a_q <= a;
            b_q <= b;
        end
    end

    ////////////////////////////////////////
    // Datapath
    // NaN: exponent all ones, fraction nonzero
    assign a_nan = (&a_q[FLEN-2 -: EXP_W]) & (|a_q[FRAC_W-1:0]);
    assign b_nan = (&b_q[FLEN-2 -: EXP_W]) & (|b_q[FRAC_W-1:0]);
    // Signaling when the quiet bit is clear
    assign a_snan = a_nan & ~a_q[FRAC_W-1];
    assign b_snan = b_nan & ~b_q[FRAC_W-1];

    // Sign-magnitude ordering, -0 below +0 through the sign test
    always_comb begin
        if (a_q[FLEN-1] != b_q[FLEN-1]) begin
            a_lt_b = a_q[FLEN-1];
        end else if (a_q[FLEN-1]) begin
            a_lt_b = a_q[FLEN-2:0] > b_q[FLEN-2:0];
        end else begin
            a_lt_b = a_q[FLEN-2:0] < b_q[FLEN-2:0];
        end
    end

    always_comb begin
        if (a_nan & b_nan) begin
            result = CANON_NAN;
        end else if (a_nan) begin
            result = b_q;
        end else if (b_nan) begin
            result = a_q;
        end else if (op_q == FMAX) begin
            result = a_lt_b ? b_q : a_q;
        end else begin
            result = a_lt_b ? a_q : b_q;
        end
    end

    // Only NV can be raised here
    always_comb begin
        wb.fflags = '0;
        wb.fflags[FFLAGS_W-1] = a_snan | b_snan;
    end

    assign wb.done = ctrl_done;
    assign wb.id = id_q;
    assign wb.rd = result;

endmodule

// ==== design/fp_sign_unit.sv ====
// Sign-injection execution unit
// FSGNJ, FSGNJN and FSGNJX in one cycle; the result is registered
// and held on the writeback interface until acknowledged

`timescale 1ns/1ps

module fp_sign_unit import fp_wb_pkg::*; (
    input logic clk,
    input logic rst,
    input logic start,
    input fp_op_e op,
    input id_t id,
    input logic [FLEN-1:0] a,
    input logic [FLEN-1:0] b,
    output logic ready,
    fp_unit_wb_if.unit wb
);

    logic sign_res;
    logic result_held;
    logic [FLEN-1:0] rd_q;
    id_t id_q;

    // Sign selection per opcode
    always_comb begin
        case (op)
            FSGNJN: sign_res = ~b[FLEN-1];
            FSGNJX: sign_res = a[FLEN-1] ^ b[FLEN-1];
            default: sign_res = b[FLEN-1];
        endcase
    end

    // Single result slot
    always_ff @(posedge clk) begin
        if (rst) begin
            result_held <= 1'b0;
        end else if (start) begin
            result_held <= 1'b1;
        end else if (wb.ack) begin
            result_held <= 1'b0;
        end
    end

    // Magnitude of a with the injected sign
    always_ff @(posedge clk) begin
        if (start) begin
            rd_q <= {sign_res, a[FLEN-2:0]};
            id_q <= id;
        end
    end

    // Free slot, or slot emptying this cycle
    assign ready = ~result_held | wb.ack;

    assign wb.done = result_held;
    assign wb.id = id_q;
    assign wb.rd = rd_q;
    // Sign injection never raises exceptions
    assign wb.fflags = '0;

endmodule

// ==== design/fp_unit_ctrl.sv ====
// Min/max unit controller
// Sequences one operation through idle, busy and done, starting the
// latency timer and the operand capture on acceptance

`timescale 1ns/1ps

module fp_unit_ctrl import fp_wb_pkg::*; (
    input logic clk,
    input logic rst,
    input logic start,
    input logic timer_expired,
    input logic ack,
    output logic ready,
    output logic timer_start,
    output logic capture,
    output logic done
);

    unit_state_e state;
    unit_state_e state_next;

    ////////////////////////////////////////
    // Next state
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = BUSY;
                end
            end
            BUSY: begin
                // Timer expiry lands done on cycle LATENCY
                if (timer_expired) begin
                    state_next = DONE;
                end
            end
            DONE: begin
                if (ack) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////
    // Outputs
    assign ready = (state == IDLE);
    // Same cycle as the accepted start
    assign timer_start = ready & start;
    assign capture = ready & start;
    assign done = (state == DONE);

endmodule

// ==== design/fp_unit_wb_if.sv ====
// Unit to writeback interface
// One execution unit's finished result with its id and flags,
// and the ack returned by the writeback arbiter

`timescale 1ns/1ps

interface fp_unit_wb_if import fp_wb_pkg::*; ();

    id_t id;
    logic done;
    logic [FLEN-1:0] rd;
    logic [FFLAGS_W-1:0] fflags;
    logic ack;

    // Execution unit side, holds result until ack
    modport unit (
        output id, done, rd, fflags,
        input ack
    );

    // Arbiter side
    modport wb (
        input id, done, rd, fflags,
        output ack
    );

endinterface

// ==== design/fp_wb_pkg.sv ====
// Floating-point writeback package
// Widths, id and opcode types, the min/max controller state encoding,
// and the packet structs shared by the writeback block and the top level

package fp_wb_pkg;

    ////////////////////////////////////////
    // Widths and constants
    localparam int FLEN = 32;
    localparam int ID_W = 4;
    localparam int FFLAGS_W = 5;

    // Units wired onto the writeback interface
    localparam int NUM_WB_UNITS = 2;

    // Quiet NaN, exponent all ones, top fraction bit only
    localparam logic [FLEN-1:0] CANON_NAN = 32'h7fc0_0000;

    typedef logic [ID_W-1:0] id_t;

    ////////////////////////////////////////
    // Opcodes and unit states
    typedef enum logic [2:0] {
        FSGNJ  = 3'd0,
        FSGNJN = 3'd1,
        FSGNJX = 3'd2,
        FMIN   = 3'd3,
        FMAX   = 3'd4
    } fp_op_e;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        BUSY = 2'd1,
        DONE = 2'd2
    } unit_state_e;

    ////////////////////////////////////////
    // Writeback packets
    // Register writeback, 37 bits
    typedef struct packed {
        logic valid;
        id_t id;
        logic [FLEN-1:0] data;
    } fp_wb_packet_t;

    // Exception flags, 10 bits, bit 4 of fflags is NV
    typedef struct packed {
        logic valid;
        id_t id;
        logic [FFLAGS_W-1:0] fflags;
    } fflags_wb_t;

endpackage

// ==== design/fp_wb_top.sv ====
// Floating-point execution back end
// Routes each dispatched operation to the sign or min/max unit and
// presents the arbitrated writeback, flag and snoop results

`timescale 1ns/1ps

module fp_wb_top import fp_wb_pkg::*; #(
    parameter int LATENCY = 4
) (
    input logic clk,
    input logic rst,
    input logic issue_valid,
    output logic issue_ready,
    input fp_op_e issue_op,
    input id_t issue_id,
    input logic [FLEN-1:0] issue_a,
    input logic [FLEN-1:0] issue_b,
    output logic wb_valid,
    output id_t wb_id,
    output logic [FLEN-1:0] wb_data,
    output logic flags_valid,
    output id_t flags_id,
    output logic [FFLAGS_W-1:0] flags,
    output logic snoop_valid,
    output id_t snoop_id,
    output logic [FLEN-1:0] snoop_data
);

    logic to_minmax;
    logic sign_ready;
    logic minmax_ready;
    logic issue_fire;

    fp_wb_packet_t wb_packet;
    fflags_wb_t fflags_packet;
    fp_wb_packet_t snoop_packet;

    // 0 is the sign unit, 1 the min/max unit
    fp_unit_wb_if unit_wb [NUM_WB_UNITS] ();

    ////////////////////////////////////////
    // Dispatch decode
    assign to_minmax = (issue_op == FMIN) || (issue_op == FMAX);
    assign issue_ready = to_minmax ? minmax_ready : sign_ready;
    assign issue_fire = issue_valid & issue_ready;

    fp_sign_unit sign_unit (
        .clk (clk),
        .rst (rst),
        .start (issue_fire & ~to_minmax),
        .op (issue_op),
        .id (issue_id),
        .a (issue_a),
        .b (issue_b),
        .ready (sign_ready),
        .wb (unit_wb[0])
    );

    fp_minmax_unit #(.LATENCY(LATENCY)) minmax_unit (
        .clk (clk),
        .rst (rst),
        .start (issue_fire & to_minmax),
        .op (issue_op),
        .id (issue_id),
        .a (issue_a),
        .b (issue_b),
        .ready (minmax_ready),
        .wb (unit_wb[1])
    );

    fp_writeback writeback (
        .clk (clk),
        .rst (rst),
        .unit_wb (unit_wb),
        .wb_packet (wb_packet),
        .fflags_packet (fflags_packet),
        .snoop_packet (snoop_packet)
    );

    ////////////////////////////////////////
    // Packet unpacking
    assign wb_valid = wb_packet.valid;
    assign wb_id = wb_packet.id;
    assign wb_data = wb_packet.data;

    assign flags_valid = fflags_packet.valid;
    assign flags_id = fflags_packet.id;
    assign flags = fflags_packet.fflags;

    assign snoop_valid = snoop_packet.valid;
    assign snoop_id = snoop_packet.id;
    assign snoop_data = snoop_packet.data;

endmodule

// ==== design/fp_writeback.sv ====
// Writeback arbiter
// Fixed-priority select of one finished unit per cycle, lowest index
// first, with the flag packet and a registered snoop copy

`timescale 1ns/1ps

module fp_writeback import fp_wb_pkg::*; (
    input logic clk,
    input logic rst,
    fp_unit_wb_if.wb unit_wb [NUM_WB_UNITS],
    output fp_wb_packet_t wb_packet,
    output fflags_wb_t fflags_packet,
    output fp_wb_packet_t snoop_packet
);

    localparam int SEL_W = (NUM_WB_UNITS > 1) ? $clog2(NUM_WB_UNITS) : 1;

    logic [NUM_WB_UNITS-1:0] unit_done;
    logic [NUM_WB_UNITS-1:0] unit_ack;
    id_t unit_id [NUM_WB_UNITS];
    logic [FLEN-1:0] unit_rd [NUM_WB_UNITS];
    logic [FFLAGS_W-1:0] unit_fflags [NUM_WB_UNITS];
    logic [SEL_W-1:0] sel;
    logic any_done;

    ////////////////////////////////////////
    // Flatten interfaces into indexable arrays
    for (genvar i = 0; i < NUM_WB_UNITS; i++) begin : g_unit
        assign unit_done[i] = unit_wb[i].done;
        assign unit_id[i] = unit_wb[i].id;
        assign unit_rd[i] = unit_wb[i].rd;
        assign unit_fflags[i] = unit_wb[i].fflags;
        assign unit_wb[i].ack = unit_ack[i];
    end

    ////////////////////////////////////////
    // Priority select
    // Downward scan leaves the lowest done index
    always_comb begin
        sel = '0;
        for (int i = NUM_WB_UNITS - 1; i >= 0; i--) begin
            if (unit_done[i]) begin
                sel = SEL_W'(i);
            end
        end
    end

    assign any_done = |unit_done;

    always_comb begin
        wb_packet.valid = any_done;
        wb_packet.id = unit_id[sel];
        wb_packet.data = unit_rd[sel];

        fflags_packet.valid = any_done;
        fflags_packet.id = unit_id[sel];
        fflags_packet.fflags = unit_fflags[sel];

        // Losers keep done high and retry
        unit_ack = '0;
        unit_ack[sel] = any_done;
    end

    ////////////////////////////////////////
    // Snoop copy for store forwarding
    always_ff @(posedge clk) begin
        if (rst) begin
            snoop_packet.valid <= 1'b0;
        end else begin
            snoop_packet.valid <= wb_packet.valid;
        end
        snoop_packet.id <= wb_packet.id;
        snoop_packet.data <= wb_packet.data;
    end

endmodule

// ==== tb.f ====
design/fp_wb_pkg.sv
design/fp_unit_wb_if.sv
design/fp_sign_unit.sv
design/fp_unit_ctrl.sv
design/fp_latency_timer.sv
design/fp_minmax_unit.sv
design/fp_writeback.sv
design/fp_wb_top.sv
tests/fp_wb_assert.sv
tests/fp_wb_tb.sv

// ==== tests/fp_wb_assert.sv ====
// Protocol checks for the floating-point back end
// Dispatch hold rule, writeback ack rules and the snoop delay

`timescale 1ns/1ps

module fp_wb_assert import fp_wb_pkg::*; (
    input logic clk,
    input logic rst,
    input logic issue_valid,
    input logic issue_ready,
    input fp_op_e issue_op,
    input id_t issue_id,
    input logic [FLEN-1:0] issue_a,
    input logic [FLEN-1:0] issue_b,
    input logic sign_done,
    input logic sign_ack,
    input logic minmax_done,
    input logic minmax_ack,
    input logic wb_valid,
    input logic snoop_valid
);

    // Waiting dispatch keeps valid and payload
    property p_issue_hold;
        @(posedge clk) disable iff (rst)
        issue_valid && !issue_ready |=> issue_valid && $stable(issue_op)
            && $stable(issue_id) && $stable(issue_a) && $stable(issue_b);
    endproperty

    // One winner per cycle
    property p_ack_onehot;
        @(posedge clk) disable iff (rst) !(sign_ack && minmax_ack);
    endproperty

    property p_ack_with_done;
        @(posedge clk) disable iff (rst)
        (!sign_ack || sign_done) && (!minmax_ack || minmax_done);
    endproperty

    // Snoop trails writeback by one cycle
    property p_snoop_delay;
        @(posedge clk) disable iff (rst) snoop_valid == $past(wb_valid);
    endproperty

    a_issue_hold: assert property (p_issue_hold)
        else $error("dispatch payload changed before the transfer");
    a_ack_onehot: assert property (p_ack_onehot)
        else $error("both units acknowledged in one cycle");
    a_ack_with_done: assert property (p_ack_with_done)
        else $error("ack raised without done");
    a_snoop_delay: assert property (p_snoop_delay)
        else $error("snoop_valid does not follow last cycle's wb_valid");

endmodule

bind fp_wb_top fp_wb_assert wb_assert (
    .clk (clk),
    .rst (rst),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_op (issue_op),
    .issue_id (issue_id),
    .issue_a (issue_a),
    .issue_b (issue_b),
    .sign_done (unit_wb[0].done),
    .sign_ack (unit_wb[0].ack),
    .minmax_done (unit_wb[1].done),
    .minmax_ack (unit_wb[1].ack),
    .wb_valid (wb_valid),
    .snoop_valid (snoop_valid)
);

// ==== tests/fp_wb_stimulus.txt ====
// Columns: opcode id a b expected_data expected_flags, all hex
// Opcodes 0 FSGNJ, 1 FSGNJN, 2 FSGNJX, 3 FMIN, 4 FMAX; first word is the line count
14
0 1 3f800000 bf800000 bf800000 00
1 2 40490fdb 3f800000 c0490fdb 00
2 3 c0000000 c0400000 40000000 00
3 4 3f800000 40000000 3f800000 00
4 5 3f800000 40000000 40000000 00
3 6 80000000 00000000 80000000 00
4 7 80000000 00000000 00000000 00
3 8 7fc00000 41200000 41200000 00
4 9 c1200000 7f800001 c1200000 10
3 a 7fc00000 ff800001 7fc00000 10
4 b 7fc00001 7fe00000 7fc00000 00
0 c 7f800001 00000000 7f800001 00
1 d bf800000 80000000 3f800000 00
2 e 40400000 bf000000 c0400000 00
3 f c0400000 c0000000 c0400000 00
4 0 c0400000 c0000000 c0000000 00
0 1 00000000 ff800000 80000000 00
4 2 ff800000 7f800000 7f800000 00
3 3 7f800000 ff800001 7f800000 10
2 4 ff800001 7f800001 ff800001 00

// ==== tests/fp_wb_tb.sv ====
// Testbench for the floating-point execution back end
// Dispatches every line of the stimulus file with random idle gaps, repeats the
// min/max lines with swapped operands, then runs directed latency, ready and
// priority sequences; a monitor checks each writeback, flag and snoop packet
// against a table of dispatched ids

`timescale 1ns/1ps

module fp_wb_tb import fp_wb_pkg::*; ();

    localparam int LATENCY = 4;
    localparam int MAX_LINES = 64;
    localparam int COLS = 6;
    localparam int NUM_IDS = 1 << ID_W;

    logic clk;
    logic rst;
    logic issue_valid;
    logic issue_ready;
    fp_op_e issue_op;
    id_t issue_id;
    logic [FLEN-1:0] issue_a;
    logic [FLEN-1:0] issue_b;
    logic wb_valid;
    id_t wb_id;
    logic [FLEN-1:0] wb_data;
    logic flags_valid;
    id_t flags_id;
    logic [FFLAGS_W-1:0] flags;
    logic snoop_valid;
    id_t snoop_id;
    logic [FLEN-1:0] snoop_data;

    // Line count word followed by six columns per line
    logic [31:0] stim_mem [0:MAX_LINES*COLS];
    int num_lines;
    int cur_line;
    int cycle;
    int outstanding;

    // Expected results by id
    bit in_flight [NUM_IDS];
    logic [FLEN-1:0] exp_data [NUM_IDS];
    logic [FFLAGS_W-1:0] exp_flags [NUM_IDS];
    int issue_cycle [NUM_IDS];
    int wb_cycle [NUM_IDS];

    // Last cycle's writeback as the snoop reference
    logic prev_valid;
    id_t prev_id;
    logic [FLEN-1:0] prev_data;

    fp_wb_top #(.LATENCY(LATENCY)) dut0 (
        .clk (clk),
        .rst (rst),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_op (issue_op),
        .issue_id (issue_id),
        .issue_a (issue_a),
        .issue_b (issue_b),
        .wb_valid (wb_valid),
        .wb_id (wb_id),
        .wb_data (wb_data),
        .flags_valid (flags_valid),
        .flags_id (flags_id),
        .flags (flags),
        .snoop_valid (snoop_valid),
        .snoop_id (snoop_id),
        .snoop_data (snoop_data)
    );

    always #20 clk = ~clk;

    // Cycle count sampled at the falling edge
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////
    // Failure reporting
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        abort_run($sformatf("** Error at %0t: %s expected %0h, actual %0h",
                            $time, name, expected, actual));
    endtask

    // Stimulus table fields
    function automatic fp_op_e line_op(input int idx);
        return fp_op_e'(stim_mem[1 + idx * COLS][2:0]);
    endfunction

    function automatic id_t line_id(input int idx);
        return stim_mem[1 + idx * COLS + 1][ID_W-1:0];
    endfunction

    ////////////////////////////////////////
    // Driver side
    // Entered just after a rising edge and returns at the transfer edge
    task automatic send_op(input int idx, input bit swap);
        int base;
        base = 1 + idx * COLS;
        cur_line = idx;
        issue_valid <= 1'b1;
        issue_op <= line_op(idx);
        issue_id <= line_id(idx);
        // Min and max give the same result in either operand order
        issue_a <= swap ? stim_mem[base + 3] : stim_mem[base + 2];
        issue_b <= swap ? stim_mem[base + 2] : stim_mem[base + 3];
        do @(negedge clk); while (issue_ready !== 1'b1);
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (outstanding != 0) @(posedge clk);
    endtask

    ////////////////////////////////////////
    // Monitor side
    task automatic check_snoop();
        assert (snoop_valid === prev_valid)
            else value_error("snoop_valid", 32'(prev_valid), 32'(snoop_valid));
        if (prev_valid) begin
            assert (snoop_id === prev_id)
                else value_error("snoop_id", 32'(prev_id), 32'(snoop_id));
            assert (snoop_data === prev_data)
                else value_error("snoop_data", prev_data, snoop_data);
        end
    endtask

    task automatic check_writeback();
        assert (flags_valid === wb_valid)
            else value_error("flags_valid", 32'(wb_valid), 32'(flags_valid));
        if (wb_valid === 1'b1) begin
            assert (flags_id === wb_id)
                else value_error("flags_id", 32'(wb_id), 32'(flags_id));
            assert (in_flight[wb_id])
                else abort_run($sformatf("Writeback of id %0h, which is not in flight", wb_id));
            assert (wb_data === exp_data[wb_id])
                else value_error("wb_data", exp_data[wb_id], wb_data);
            assert (flags === exp_flags[wb_id])
                else value_error("flags", 32'(exp_flags[wb_id]), 32'(flags));
            in_flight[wb_id] = 1'b0;
            wb_cycle[wb_id] = cycle;
            outstanding = outstanding - 1;
        end
    endtask

    // Transfer seen here completes at the next rising edge
    task automatic record_issue();
        int base;
        base = 1 + cur_line * COLS;
        if (issue_valid && issue_ready) begin
            assert (!in_flight[issue_id])
                else abort_run($sformatf("Id %0h dispatched while still in flight", issue_id));
            in_flight[issue_id] = 1'b1;
            exp_data[issue_id] = stim_mem[base + 4];
            exp_flags[issue_id] = stim_mem[base + 5][FFLAGS_W-1:0];
            issue_cycle[issue_id] = cycle;
            outstanding = outstanding + 1;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_snoop();
            check_writeback();
            record_issue();
            prev_valid = wb_valid;
            prev_id = wb_id;
            prev_data = wb_data;
        end else begin
            prev_valid = 1'b0;
        end
    end

    // Watchdog sized from the number of stimulus lines
    initial begin
        int limit;
        @(posedge clk);
        limit = num_lines * (LATENCY + 8) + 50;
        repeat (limit) @(posedge clk);
        abort_run("Timeout: not every dispatched id was written back");
    end

    ////////////////////////////////////////
    // Main sequence
    initial begin
        int gap;
        int mm_idx;
        int sg_idx;
        int target;
        id_t mm_id;
        id_t sg_id;

        clk = 1'b0;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_op = FSGNJ;
        issue_id = '0;
        issue_a = '0;
        issue_b = '0;
        cycle = 0;
        cur_line = 0;
        outstanding = 0;
        prev_valid = 1'b0;
        prev_id = '0;
        prev_data = '0;
        for (int i = 0; i < NUM_IDS; i++) begin
            in_flight[i] = 1'b0;
        end
        void'($urandom(28));
        $readmemh("tests/fp_wb_stimulus.txt", stim_mem);
        num_lines = int'(stim_mem[0]);
        assert (num_lines > 0 && num_lines <= MAX_LINES)
            else abort_run("Stimulus file has no valid line count");

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Idle outputs after reset
        @(negedge clk);
        assert (issue_ready === 1'b1) else value_error("issue_ready", 1, 32'(issue_ready));
        assert (wb_valid === 1'b0) else value_error("wb_valid", 0, 32'(wb_valid));
        assert (flags_valid === 1'b0) else value_error("flags_valid", 0, 32'(flags_valid));
        assert (snoop_valid === 1'b0) else value_error("snoop_valid", 0, 32'(snoop_valid));
        @(posedge clk);

        // Every line with random idle gaps
        for (int i = 0; i < num_lines; i++) begin
            send_op(i, 1'b0);
            gap = $urandom_range(3, 0);
            repeat (gap) @(posedge clk);
        end
        wait_drain();

        // Min/max lines again with a and b exchanged
        for (int i = 0; i < num_lines; i++) begin
            if (line_op(i) == FMIN || line_op(i) == FMAX) begin
                send_op(i, 1'b1);
            end
        end
        wait_drain();

        // First min/max line and first sign line
        mm_idx = -1;
        sg_idx = -1;
        for (int i = 0; i < num_lines; i++) begin
            if ((line_op(i) == FMIN || line_op(i) == FMAX) && mm_idx < 0) begin
                mm_idx = i;
            end else if (line_op(i) != FMIN && line_op(i) != FMAX && sg_idx < 0) begin
                sg_idx = i;
            end
        end
        assert (mm_idx >= 0 && sg_idx >= 0)
            else abort_run("Stimulus file needs a sign line and a min/max line");
        mm_id = line_id(mm_idx);
        sg_id = line_id(sg_idx);
        assert (mm_id != sg_id) else abort_run("Directed lines share one id");

        // Uncontended min/max and ready per opcode while busy
        send_op(mm_idx, 1'b0);
        issue_op <= FMIN;
        @(negedge clk);
        assert (issue_ready === 1'b0) else value_error("issue_ready", 0, 32'(issue_ready));
        @(posedge clk);
        issue_op <= FSGNJ;
        @(negedge clk);
        assert (issue_ready === 1'b1) else value_error("issue_ready", 1, 32'(issue_ready));
        @(posedge clk);
        wait_drain();
        assert (wb_cycle[mm_id] - issue_cycle[mm_id] == LATENCY)
            else value_error("min/max latency", LATENCY,
                             32'(wb_cycle[mm_id] - issue_cycle[mm_id]));

        // Uncontended sign op
        send_op(sg_idx, 1'b0);
        wait_drain();
        assert (wb_cycle[sg_id] - issue_cycle[sg_id] == 1)
            else value_error("sign latency", 1, 32'(wb_cycle[sg_id] - issue_cycle[sg_id]));

        // Sign result lands on the min/max done cycle
        send_op(mm_idx, 1'b0);
        target = issue_cycle[mm_id] + LATENCY - 1;
        if (LATENCY > 2) begin
            do @(negedge clk); while (cycle < target - 1);
            @(posedge clk);
        end
        send_op(sg_idx, 1'b0);
        wait_drain();
        assert (wb_cycle[sg_id] == issue_cycle[mm_id] + LATENCY)
            else value_error("sign writeback cycle", 32'(issue_cycle[mm_id] + LATENCY),
                             32'(wb_cycle[sg_id]));
        // Loser held done for one more cycle
        assert (wb_cycle[mm_id] == wb_cycle[sg_id] + 1)
            else value_error("min/max writeback cycle", 32'(wb_cycle[sg_id] + 1),
                             32'(wb_cycle[mm_id]));

        $display("PASS: all tests");
        $finish;
    end

endmodule
